// ==== Makefile ====
SIM      = verilator
SIMFLAGS = --binary --timing --assert
TOP      = tb_load_wb_top
FILELIST = load_wb_top.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== load_wb_top.f ====
logic/lsu_pkg.sv
logic/data_ram.sv
logic/mem_stage.sv
logic/load_extend.sv
logic/unaligned_merge.sv
logic/wb_stage.sv
logic/reg_file.sv
logic/load_wb_top.sv
test/clock_gen.sv
test/load_wb_properties.sv
test/tb_load_wb_top.sv

// ==== logic/data_ram.sv ====
`timescale 1ns/100ps

module data_ram (
    input  logic                          clk,
    input  logic                          en,
    input  logic [3:0]                    we,
    input  logic [lsu_pkg::RAM_ADDR_W-1:0] addr,
    input  logic [lsu_pkg::XLEN-1:0]       wdata,
    output logic [lsu_pkg::XLEN-1:0]       rdata
);
    import lsu_pkg::*;

    // word organized, one byte lane per strobe
    logic [XLEN-1:0] mem [RAM_WORDS];

    // --------------------
    // access port
    // --------------------
    // read and write share the enable; a read in the same cycle as a
    // write to that word still sees the previous contents
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata <= mem[addr];                 // registered read
        end
    end

endmodule

// ==== logic/load_extend.sv ====
`timescale 1ns/100ps

module load_extend (
    input  logic [lsu_pkg::XLEN-1:0] word,
    input  logic [1:0]               adrl,
    input  lsu_pkg::mem_op_e         op,
    output logic [lsu_pkg::XLEN-1:0] ext_out
);
    import lsu_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // addressed byte and halfword
    assign sel_byte = word[8*adrl +: 8];
    assign sel_half = adrl[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (op)
            OP_LB: begin
                ext_out = {{(XLEN-8){sel_byte[7]}}, sel_byte};
            end
            OP_LBU: begin
                ext_out = {{(XLEN-8){1'b0}}, sel_byte};
            end
            OP_LH: begin
                ext_out = {{(XLEN-16){sel_half[15]}}, sel_half};
            end
            OP_LHU: begin
                ext_out = {{(XLEN-16){1'b0}}, sel_half};
            end
            default: begin
                ext_out = word;                 // lw, full word
            end
        endcase
    end

endmodule

// ==== logic/load_wb_top.sv ====
`timescale 1ns/100ps

module load_wb_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  lsu_pkg::mem_op_e               in_op,
    input  logic [lsu_pkg::XLEN-1:0]       in_pc,
    input  logic [lsu_pkg::XLEN-1:0]       in_addr,
    input  logic [lsu_pkg::XLEN-1:0]       in_store_data,
    input  logic [lsu_pkg::XLEN-1:0]       in_alu_result,
    input  logic [lsu_pkg::REG_ADDR_W-1:0] in_wnum,
    input  logic [lsu_pkg::REG_ADDR_W-1:0] rf_raddr,
    output logic [lsu_pkg::XLEN-1:0]       rf_rdata,
    output logic [lsu_pkg::XLEN-1:0]       debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_wen,
    output logic [lsu_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [lsu_pkg::XLEN-1:0]       debug_wb_rf_wdata
);
    import lsu_pkg::*;

    // ram port
    logic                  ram_en;
    logic [3:0]            ram_we;
    logic [RAM_ADDR_W-1:0] ram_addr;
    logic [XLEN-1:0]       ram_wdata;
    logic [XLEN-1:0]       ram_rdata;

    // memory to writeback
    logic                  mem_valid;
    mem_op_e               mem_op;
    logic [XLEN-1:0]       mem_pc;
    logic [1:0]            mem_adrl;
    logic [XLEN-1:0]       mem_wbdata;
    logic [REG_ADDR_W-1:0] mem_wnum;

    // register file write
    logic [3:0]            rf_we;
    logic [REG_ADDR_W-1:0] rf_wnum;
    logic [XLEN-1:0]       rf_wdata;

    mem_stage u_mem_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_op         (in_op),
        .in_pc         (in_pc),
        .in_addr       (in_addr),
        .in_store_data (in_store_data),
        .in_alu_result (in_alu_result),
        .in_wnum       (in_wnum),
        .ram_en        (ram_en),
        .ram_we        (ram_we),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata),
        .mem_valid     (mem_valid),
        .mem_op        (mem_op),
        .mem_pc        (mem_pc),
        .mem_adrl      (mem_adrl),
        .mem_wbdata    (mem_wbdata),
        .mem_wnum      (mem_wnum)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    wb_stage u_wb_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .mem_valid         (mem_valid),
        .mem_op            (mem_op),
        .mem_pc            (mem_pc),
        .mem_adrl          (mem_adrl),
        .mem_wbdata        (mem_wbdata),
        .mem_wnum          (mem_wnum),
        .dm_rdata          (ram_rdata),
        .rf_we             (rf_we),
        .rf_wnum           (rf_wnum),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .we    (rf_we),
        .wnum  (rf_wnum),
        .wdata (rf_wdata),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

endmodule

// ==== logic/lsu_pkg.sv ====
package lsu_pkg;

    // --------------------
    // widths and sizes
    // --------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;              // 32 architectural registers
    localparam int RAM_WORDS  = 256;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

    // --------------------
    // instruction class
    // --------------------
    typedef enum logic [3:0] {
        OP_ALU,                                 // plain alu result to rd
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_LWL,                                 // unaligned left part
        OP_LWR,                                 // unaligned right part
        OP_SB,
        OP_SH,
        OP_SW,
        OP_NONE                                 // bubble, writes nothing
    } mem_op_e;

    // loads that read the data ram
    function automatic logic is_load(mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR: is_load = 1'b1;
            default: is_load = 1'b0;
        endcase
    endfunction

    function automatic logic is_store(mem_op_e op);
        case (op)
            OP_SB, OP_SH, OP_SW: is_store = 1'b1;
            default: is_store = 1'b0;
        endcase
    endfunction

endpackage

// ==== logic/mem_stage.sv ====
`timescale 1ns/100ps

module mem_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    // from execute
    input  logic                           in_valid,
    input  lsu_pkg::mem_op_e               in_op,
    input  logic [lsu_pkg::XLEN-1:0]       in_pc,
    input  logic [lsu_pkg::XLEN-1:0]       in_addr,
    input  logic [lsu_pkg::XLEN-1:0]       in_store_data,
    input  logic [lsu_pkg::XLEN-1:0]       in_alu_result,
    input  logic [lsu_pkg::REG_ADDR_W-1:0] in_wnum,
    // data ram request
    output logic                           ram_en,
    output logic [3:0]                     ram_we,
    output logic [lsu_pkg::RAM_ADDR_W-1:0] ram_addr,
    output logic [lsu_pkg::XLEN-1:0]       ram_wdata,
    // to writeback
    output logic                           mem_valid,
    output lsu_pkg::mem_op_e               mem_op,
    output logic [lsu_pkg::XLEN-1:0]       mem_pc,
    output logic [1:0]                     mem_adrl,
    output logic [lsu_pkg::XLEN-1:0]       mem_wbdata,
    output logic [lsu_pkg::REG_ADDR_W-1:0] mem_wnum
);
    import lsu_pkg::*;

    // --------------------
    // ram request
    // --------------------
    assign ram_en   = in_valid && (is_load(in_op) || is_store(in_op));
    assign ram_addr = in_addr[RAM_ADDR_W+1:2];  // word address

    // store lanes: data replicated, strobes pick the addressed bytes
    always_comb begin
        ram_we    = 4'b0000;
        ram_wdata = in_store_data;
        if (in_valid) begin
            case (in_op)
                OP_SB: begin
                    ram_we    = 4'b0001 << in_addr[1:0];
                    ram_wdata = {4{in_store_data[7:0]}};
                end
                OP_SH: begin
                    ram_we    = in_addr[1] ? 4'b1100 : 4'b0011;
                    ram_wdata = {2{in_store_data[15:0]}};
                end
                OP_SW: begin
                    ram_we    = 4'b1111;
                end
                default: begin
                    ram_we    = 4'b0000;    // loads and alu ops
                end
            endcase
        end
    end

    // --------------------
    // pipeline register
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
            mem_op    <= OP_NONE;
        end else begin
            mem_valid <= in_valid;
            mem_op    <= in_valid ? in_op : OP_NONE;  // empty slot writes nothing
        end
    end

    // payload only follows a valid slot
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem_pc     <= in_pc;
            mem_adrl   <= in_addr[1:0];
            mem_wbdata <= in_alu_result;
            mem_wnum   <= in_wnum;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic                           clk,
    input  logic [3:0]                     we,
    input  logic [lsu_pkg::REG_ADDR_W-1:0] wnum,
    input  logic [lsu_pkg::XLEN-1:0]       wdata,
    input  logic [lsu_pkg::REG_ADDR_W-1:0] raddr,
    output logic [lsu_pkg::XLEN-1:0]       rdata
);
    import lsu_pkg::*;

    logic [XLEN-1:0] regs [1 << REG_ADDR_W];

    // --------------------
    // write port
    // --------------------
    // byte enables keep the lanes that lwl/lwr leave alone
    always_ff @(posedge clk) begin
        if (wnum != '0) begin                   // r0 is hardwired
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    regs[wnum][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // --------------------
    // read port
    // --------------------
    assign rdata = (raddr == '0) ? '0 : regs[raddr];   // combinational

endmodule

// ==== logic/unaligned_merge.sv ====
`timescale 1ns/100ps

module unaligned_merge (
    input  logic [lsu_pkg::XLEN-1:0] word,
    input  logic [1:0]               adrl,
    input  lsu_pkg::mem_op_e         op,
    output logic [lsu_pkg::XLEN-1:0] merge_data,
    output logic [3:0]               merge_we
);
    import lsu_pkg::*;

    logic [1:0]        rot_bytes;
    logic [2*XLEN-1:0] rot_dbl;

    // --------------------
    // byte rotation
    // --------------------
    // lwl: byte adrl goes to lane 3, a right rotate by adrl+1 bytes
    // lwr: byte adrl goes to lane 0, a right rotate by adrl bytes
    assign rot_bytes = (op == OP_LWL) ? adrl + 2'd1 : adrl;   // wraps mod 4
    assign rot_dbl   = {word, word} >> (8 * rot_bytes);

    always_comb begin
        case (op)
            OP_LWL: begin
                merge_data = rot_dbl[XLEN-1:0];
                merge_we   = 4'b1111 << (2'd3 - adrl);  // lanes 3 down to 3-adrl
            end
            OP_LWR: begin
                merge_data = rot_dbl[XLEN-1:0];
                merge_we   = 4'b1111 >> adrl;           // lanes 0 up to 3-adrl
            end
            default: begin
                merge_data = word;
                merge_we   = 4'b0000;
            end
        endcase
    end

endmodule

// ==== logic/wb_stage.sv ====
`timescale 1ns/100ps

module wb_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    // from memory stage
    input  logic                           mem_valid,
    input  lsu_pkg::mem_op_e               mem_op,
    input  logic [lsu_pkg::XLEN-1:0]       mem_pc,
    input  logic [1:0]                     mem_adrl,
    input  logic [lsu_pkg::XLEN-1:0]       mem_wbdata,
    input  logic [lsu_pkg::REG_ADDR_W-1:0] mem_wnum,
    input  logic [lsu_pkg::XLEN-1:0]       dm_rdata,
    // register file write port
    output logic [3:0]                     rf_we,
    output logic [lsu_pkg::REG_ADDR_W-1:0] rf_wnum,
    output logic [lsu_pkg::XLEN-1:0]       rf_wdata,
    // write trace
    output logic [lsu_pkg::XLEN-1:0]       debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_wen,
    output logic [lsu_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [lsu_pkg::XLEN-1:0]       debug_wb_rf_wdata
);
    import lsu_pkg::*;

    logic [XLEN-1:0]       ext_out;
    logic [XLEN-1:0]       merge_data;
    logic [3:0]            merge_we;
    logic [3:0]            sel_we;
    logic [XLEN-1:0]       sel_wdata;

    logic                  wb_valid;
    logic [3:0]            wb_we;
    logic [XLEN-1:0]       wb_pc;
    logic [REG_ADDR_W-1:0] wb_wnum;
    logic [XLEN-1:0]       wb_wdata;

    load_extend u_load_extend (
        .word    (dm_rdata),
        .adrl    (mem_adrl),
        .op      (mem_op),
        .ext_out (ext_out)
    );

    unaligned_merge u_unaligned_merge (
        .word       (dm_rdata),
        .adrl       (mem_adrl),
        .op         (mem_op),
        .merge_data (merge_data),
        .merge_we   (merge_we)
    );

    // --------------------
    // writeback select
    // --------------------
    always_comb begin
        case (mem_op)
            OP_ALU: begin
                sel_wdata = mem_wbdata;
                sel_we    = 4'b1111;
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                sel_wdata = ext_out;
                sel_we    = 4'b1111;
            end
            OP_LWL, OP_LWR: begin
                sel_wdata = merge_data;
                sel_we    = merge_we;           // partial word
            end
            default: begin
                sel_wdata = mem_wbdata;
                sel_we    = 4'b0000;            // stores and bubbles
            end
        endcase
    end

    assign rf_we    = mem_valid ? sel_we : 4'b0000;
    assign rf_wnum  = mem_wnum;
    assign rf_wdata = sel_wdata;

    // --------------------
    // writeback register
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_we    <= 4'b0000;
        end else begin
            wb_valid <= mem_valid;
            wb_we    <= rf_we;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc    <= mem_pc;
        wb_wnum  <= rf_wnum;
        wb_wdata <= rf_wdata;
    end

    // trace, one cycle behind the writeback register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            debug_wb_rf_wen <= 4'b0000;
        end else begin
            debug_wb_rf_wen <= wb_valid ? wb_we : 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        debug_wb_pc       <= wb_pc;
        debug_wb_rf_wnum  <= wb_wnum;
        debug_wb_rf_wdata <= wb_wdata;
    end

endmodule

// ==== test/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held low over the first few rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== test/load_wb_properties.sv ====
`timescale 1ns/100ps

module load_wb_properties (
    input logic             clk,
    input logic             rst_n,
    input logic             mem_valid,
    input lsu_pkg::mem_op_e mem_op,
    input logic [1:0]       mem_adrl,
    input logic [3:0]       rf_we,
    input logic [3:0]       debug_wen
);
    import lsu_pkg::*;

    // --------------------
    // reset behavior
    // --------------------
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (rf_we == 4'b0000) && (debug_wen == 4'b0000))
        else $error("register write enable set during or right after reset");

    // trace sits two edges behind the register file write
    trace_follows_write: assert property (@(posedge clk) disable iff (!rst_n)
        (debug_wen != 4'b0000) |-> (debug_wen == $past(rf_we, 2)))
        else $error("debug trace wen does not match the earlier register write");

    // --------------------
    // unaligned lanes
    // --------------------
    lwl_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_valid && mem_op == OP_LWL) |->
            (rf_we inside {4'b1000, 4'b1100, 4'b1110, 4'b1111}) &&
            ($countones(rf_we) == mem_adrl + 1))
        else $error("lwl byte enables do not cover lanes 3 down to 3-adrl");

    lwr_lanes: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_valid && mem_op == OP_LWR) |->
            (rf_we inside {4'b0001, 4'b0011, 4'b0111, 4'b1111}) &&
            ($countones(rf_we) == 4 - mem_adrl))
        else $error("lwr byte enables do not cover lanes 0 up to 3-adrl");

endmodule

// ==== test/tb_load_wb_top.sv ====
`timescale 1ns/100ps

module tb_load_wb_top;
    import lsu_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int MAX_ROWS   = 40;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    mem_op_e               in_op;
    logic [XLEN-1:0]       in_pc;
    logic [XLEN-1:0]       in_addr;
    logic [XLEN-1:0]       in_store_data;
    logic [XLEN-1:0]       in_alu_result;
    logic [REG_ADDR_W-1:0] in_wnum;
    logic [REG_ADDR_W-1:0] rf_raddr;
    logic [XLEN-1:0]       rf_rdata;
    logic [XLEN-1:0]       debug_wb_pc;
    logic [3:0]            debug_wb_rf_wen;
    logic [REG_ADDR_W-1:0] debug_wb_rf_wnum;
    logic [XLEN-1:0]       debug_wb_rf_wdata;

    // --------------------
    // stimulus table
    // --------------------
    logic                  t_valid [MAX_ROWS];
    mem_op_e               t_op    [MAX_ROWS];
    logic [31:0]           t_pc    [MAX_ROWS];
    logic [31:0]           t_addr  [MAX_ROWS];
    logic [31:0]           t_sdata [MAX_ROWS];
    logic [31:0]           t_alu   [MAX_ROWS];
    logic [4:0]            t_wnum  [MAX_ROWS];
    logic [4:0]            t_raddr [MAX_ROWS];
    int                    n_rows = 0;
    integer                seed;

    // reference model
    logic [31:0]           model_mem  [RAM_WORDS];
    logic [31:0]           model_regs [32];
    logic [3:0]            row_we     [MAX_ROWS];
    logic [31:0]           row_wdata  [MAX_ROWS];
    int                    exp_due   [$];           // cycle the trace entry shows up
    logic [31:0]           exp_pc    [$];
    logic [31:0]           exp_wen   [$];
    logic [31:0]           exp_wnum  [$];
    logic [31:0]           exp_wdata [$];

    bit                    run_passed    = 1'b0;
    bit                    fail_reported = 1'b0;

    clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    load_wb_top u_load_wb_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .in_valid          (in_valid),
        .in_op             (in_op),
        .in_pc             (in_pc),
        .in_addr           (in_addr),
        .in_store_data     (in_store_data),
        .in_alu_result     (in_alu_result),
        .in_wnum           (in_wnum),
        .rf_raddr          (rf_raddr),
        .rf_rdata          (rf_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    bind wb_stage load_wb_properties u_load_wb_properties (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_valid (mem_valid),
        .mem_op    (mem_op),
        .mem_adrl  (mem_adrl),
        .rf_we     (rf_we),
        .debug_wen (debug_wb_rf_wen)
    );

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Simulation failed");
            fail_reported = 1'b1;
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic add_row(input logic valid, input mem_op_e op, input int addr,
                           input int wnum, input int raddr);
        t_valid[n_rows] = valid;
        t_op[n_rows]    = op;
        t_pc[n_rows]    = 32'h0000_1000 + 32'(4 * n_rows);
        t_addr[n_rows]  = 32'(addr);
        t_sdata[n_rows] = $random(seed);
        t_alu[n_rows]   = $random(seed);
        t_wnum[n_rows]  = 5'(wnum);
        t_raddr[n_rows] = 5'(raddr);
        n_rows++;
    endtask

    task automatic build_table();
        add_row(1'b1, OP_ALU, 0, 1, 0);
        add_row(1'b0, OP_ALU, 0, 2, 0);             // bubble
        add_row(1'b1, OP_ALU, 0, 2, 1);
        // each store read back right away
        add_row(1'b1, OP_SW, 'h40, 0, 1);
        add_row(1'b1, OP_LW, 'h40, 3, 2);
        add_row(1'b1, OP_SB, 'h41, 0, 2);
        add_row(1'b1, OP_LW, 'h40, 4, 3);
        add_row(1'b1, OP_SH, 'h42, 0, 3);
        add_row(1'b1, OP_LW, 'h40, 5, 4);
        add_row(1'b1, OP_SW, 'h44, 0, 4);
        for (int a = 0; a < 4; a++) begin
            add_row(1'b1, OP_LB, 'h40 + a, 6, 5);
            add_row(1'b1, OP_LBU, 'h40 + a, 7, 5);
        end
        for (int a = 0; a < 4; a += 2) begin
            add_row(1'b1, OP_LH, 'h40 + a, 8, 6);
            add_row(1'b1, OP_LHU, 'h40 + a, 9, 6);
        end
        // lwr fetches the low part and lwl the high part of the word at 0x40+a
        for (int a = 0; a < 4; a++) begin
            add_row(1'b1, OP_LWR, 'h40 + a, 10 + a, 9);
            add_row(1'b1, OP_LWL, 'h43 + a, 10 + a, 9 + a);
        end
        add_row(1'b1, OP_ALU, 0, 0, 9);             // r0 write still traced
        add_row(1'b0, OP_NONE, 0, 0, 13);
        add_row(1'b0, OP_NONE, 0, 0, 0);
    endtask

    // --------------------
    // reference model
    // --------------------
    task automatic predict_row(input int i);
        logic [31:0] word;
        logic [31:0] data;
        logic [3:0]  wen;
        int          w;
        int          a;
        w    = int'((t_addr[i] >> 2) % RAM_WORDS);
        a    = int'(t_addr[i][1:0]);
        word = model_mem[w];
        data = t_alu[i];
        wen  = 4'b0000;
        if (t_valid[i]) begin
            case (t_op[i])
                OP_ALU: wen = 4'b1111;
                OP_SB:  model_mem[w][8*a +: 8] = t_sdata[i][7:0];
                OP_SH:  model_mem[w][8*a +: 16] = t_sdata[i][15:0];
                OP_SW:  model_mem[w] = t_sdata[i];
                OP_LB: begin
                    wen  = 4'b1111;
                    data = {{24{word[8*a+7]}}, word[8*a +: 8]};
                end
                OP_LBU: begin
                    wen  = 4'b1111;
                    data = {24'h0, word[8*a +: 8]};
                end
                OP_LH: begin
                    wen  = 4'b1111;
                    data = {{16{word[8*a+15]}}, word[8*a +: 16]};
                end
                OP_LHU: begin
                    wen  = 4'b1111;
                    data = {16'h0, word[8*a +: 16]};
                end
                OP_LW: begin
                    wen  = 4'b1111;
                    data = word;
                end
                OP_LWL: begin
                    for (int l = 0; l < 4; l++) begin
                        data[8*l +: 8] = word[8*((l + a + 1) % 4) +: 8];  // byte a in lane 3
                        wen[l]         = (l >= 3 - a);
                    end
                end
                OP_LWR: begin
                    for (int l = 0; l < 4; l++) begin
                        data[8*l +: 8] = word[8*((l + a) % 4) +: 8];      // byte a in lane 0
                        wen[l]         = (l <= 3 - a);
                    end
                end
                default: wen = 4'b0000;
            endcase
        end
        row_we[i]    = wen;
        row_wdata[i] = data;
        if (wen != 4'b0000) begin
            exp_due.push_back(i + 3);
            exp_pc.push_back(t_pc[i]);
            exp_wen.push_back(32'(wen));
            exp_wnum.push_back(32'(t_wnum[i]));
            exp_wdata.push_back(data);
        end
    endtask

    // register file picks up row j two edges after it was driven
    task automatic retire_row(input int j);
        for (int l = 0; l < 4; l++) begin
            if (row_we[j][l] && t_wnum[j] != 5'd0) begin
                model_regs[t_wnum[j]][8*l +: 8] = row_wdata[j][8*l +: 8];
            end
        end
    endtask

    function automatic logic [31:0] expected_read(input logic [4:0] r);
        if (r == 5'd0) begin
            return 32'h0;                           // r0 always reads zero
        end
        return model_regs[r];
    endfunction

    task automatic apply_row(input int c);
        if (c < n_rows) begin
            in_valid      = t_valid[c];
            in_op         = t_op[c];
            in_pc         = t_pc[c];
            in_addr       = t_addr[c];
            in_store_data = t_sdata[c];
            in_alu_result = t_alu[c];
            in_wnum       = t_wnum[c];
            rf_raddr      = t_raddr[c];
            predict_row(c);
        end else begin
            in_valid = 1'b0;                        // drain
            in_op    = OP_NONE;
            rf_raddr = 5'd0;
        end
    endtask

    task automatic check_trace(input int cyc);
        if (exp_due.size() != 0 && exp_due[0] == cyc) begin
            check(debug_wb_pc, exp_pc.pop_front(), "trace pc");
            check(32'(debug_wb_rf_wen), exp_wen.pop_front(), "trace wen");
            check(32'(debug_wb_rf_wnum), exp_wnum.pop_front(), "trace wnum");
            check(debug_wb_rf_wdata, exp_wdata.pop_front(), "trace wdata");
            void'(exp_due.pop_front());
        end else begin
            check(32'(debug_wb_rf_wen), 32'h0, "trace write with no instruction behind it");
        end
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        in_valid      = 1'b0;
        in_op         = OP_NONE;
        in_pc         = '0;
        in_addr       = '0;
        in_store_data = '0;
        in_alu_result = '0;
        in_wnum       = '0;
        rf_raddr      = '0;
        seed          = 32'had6c;
        build_table();
        wait (rst_n === 1'b1);
        for (int c = 0; c < n_rows + 4; c++) begin
            @(posedge clk);
            #1;
            check_trace(c);
            if (c >= 2 && c - 2 < n_rows) begin
                retire_row(c - 2);
            end
            apply_row(c);
            #1;
            check(rf_rdata, expected_read(rf_raddr), "register read port");
        end
        run_passed = 1'b1;
        $display("Simulation completed successfully");
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (n_rows != 0);
        #((n_rows + 20) * CLK_PERIOD);
        $display("Timeout: run still going after %0d cycles", n_rows + 20);
        $display("Simulation failed");
        fail_reported = 1'b1;
        $fatal(1, "watchdog expired");
    end

    // run stopped early by a failed assertion
    final begin
        if (!run_passed && !fail_reported) begin
            $display("Simulation failed");
        end
    end

endmodule
